//--- Makefile
# Verilator flow for the instruction cache

VERILATOR ?= verilator
TOP       ?= tb_icache
RTL_TOP   ?= icache_top
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

RTL_FILES = common/icache_pkg.sv icache/icache_way_array.sv icache/icache_checker.sv \
            icache/icache_replace_unit.sv icache/icache_ctrl.sv icache/icache_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
common/icache_pkg.sv
icache/icache_way_array.sv
icache/icache_checker.sv
icache/icache_replace_unit.sv
icache/icache_ctrl.sv
icache/icache_top.sv
test/tb_icache.sv

//--- common/icache_pkg.sv
// Instruction cache definitions
package icache_pkg;

    // Address split
    localparam int VPN_WIDTH        = 20;
    localparam int IDX_WIDTH        = 12;   // Page offset
    localparam int PPN_WIDTH        = 20;   // Tag is the whole PPN

    // Geometry
    localparam int N_WAY            = 2;
    localparam int N_SET            = 16;
    localparam int SET_WIDTH        = 4;    // Page offset bits 7 to 4
    localparam int OFFSET_WIDTH     = 4;    // Byte within a line

    // Line and refill beats
    localparam int LINE_WIDTH       = 128;
    localparam int BEAT_WIDTH       = 64;
    localparam int N_BEAT           = 2;
    localparam int PADDR_LINE_WIDTH = 28;

    // --------------------
    // Vector types
    typedef logic [VPN_WIDTH-1:0]      vpn_t;
    typedef logic [IDX_WIDTH-1:0]      idx_t;
    typedef logic [PPN_WIDTH-1:0]      ppn_t;
    typedef logic [SET_WIDTH-1:0]      set_t;
    typedef logic [$clog2(N_WAY)-1:0]  way_t;
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [BEAT_WIDTH-1:0]     beat_t;

    // --------------------
    // Controller states
    typedef enum logic [2:0] {
        IDLE,       // Ready for a request or a flush
        LOOKUP,     // Translation pending, then tag check
        MMU_WAIT,   // Page walk in progress
        FILL_REQ,   // Refill sent, no beat yet
        FILL_WAIT,  // Remaining refill beats
        FLUSH       // Clearing valid bits
    } ctrl_state_t;

endpackage

//--- icache/icache_checker.sv
// Tag compare and way select
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; (
    input  ppn_t  [N_WAY-1:0]  tags_i,
    input  line_t [N_WAY-1:0]  lines_i,
    input  logic  [N_WAY-1:0]  valid_i,
    input  ppn_t               ppn_i,     // Registered translation
    input  logic               cmp_en_i,
    output logic  [N_WAY-1:0]  hit_o,
    output line_t              line_o
);

    always_comb begin
        line_o = '0;
        for (int w = 0; w < N_WAY; w++) begin
            hit_o[w] = cmp_en_i && valid_i[w] && (tags_i[w] == ppn_i);
            // One-hot hit, so an OR of masked lines is the mux
            line_o   = line_o | (lines_i[w] & {LINE_WIDTH{hit_o[w]}});
        end
    end

endmodule

//--- icache/icache_ctrl.sv
// Instruction cache controller
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  ireq_valid_i,
    input  logic  ireq_kill_i,
    input  logic  tresp_valid_i,       // Held until the next translation request
    input  logic  tresp_miss_i,
    input  logic  tresp_ptw_valid_i,
    input  logic  tresp_xcpt_i,
    input  logic  hit_i,
    input  logic  fill_beat_valid_i,
    input  logic  fill_last_i,
    output logic  ready_o,
    output logic  treq_valid_o,
    output logic  cmp_en_o,
    output logic  rd_en_o,
    output logic  wr_en_o,
    output logic  flush_en_o,
    output logic  fill_req_o,
    output logic  resp_valid_o,
    output logic  miss_time_o,
    output logic  miss_kill_o
);

    ctrl_state_t  state_q;
    ctrl_state_t  state_d;
    logic         kill_q;     // Kill seen for the request in flight
    logic         killed;
    logic         in_fill;

    assign killed  = kill_q || ireq_kill_i;
    assign in_fill = (state_q == FILL_REQ) || (state_q == FILL_WAIT);

    // A pending flush blocks new requests
    assign ready_o     = (state_q == IDLE) && !flush_i;
    assign rd_en_o     = ready_o && ireq_valid_i;
    assign cmp_en_o    = (state_q == LOOKUP);
    assign flush_en_o  = (state_q == FLUSH);
    assign miss_time_o = in_fill;
    assign wr_en_o     = in_fill && fill_beat_valid_i;

    // --------------------
    // Next state
    always_comb begin
        state_d      = state_q;
        treq_valid_o = 1'b0;
        fill_req_o   = 1'b0;
        resp_valid_o = 1'b0;
        miss_kill_o  = 1'b0;

        case (state_q)
            IDLE: begin
                if (flush_i) begin
                    state_d = FLUSH;
                end else if (rd_en_o) begin
                    treq_valid_o = 1'b1;  // Translation alongside array read
                    state_d      = LOOKUP;
                end
            end

            LOOKUP: begin
                // First cycle waits for the MMU, second one decides
                if (tresp_valid_i) begin
                    if (killed) begin
                        miss_kill_o = !tresp_miss_i && !tresp_xcpt_i && !hit_i;
                        state_d     = IDLE;
                    end else if (tresp_miss_i) begin
                        state_d = MMU_WAIT;
                    end else if (tresp_xcpt_i || hit_i) begin
                        resp_valid_o = 1'b1;
                        state_d      = IDLE;
                    end else begin
                        fill_req_o = 1'b1;    // Single pulse
                        state_d    = FILL_REQ;
                    end
                end
            end

            MMU_WAIT: begin
                if (killed) begin
                    state_d = IDLE;
                end else if (tresp_ptw_valid_i) begin
                    treq_valid_o = 1'b1;  // Retry after the walk
                    state_d      = LOOKUP;
                end
            end

            FILL_REQ, FILL_WAIT: begin
                // Refill runs to the end even when killed
                miss_kill_o = ireq_kill_i && !kill_q;
                if (fill_beat_valid_i && fill_last_i) begin
                    state_d = LOOKUP;         // Line now hits
                end else if (fill_beat_valid_i) begin
                    state_d = FILL_WAIT;
                end
            end

            FLUSH:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // --------------------
    // State and kill registers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            kill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            kill_q  <= (state_d == IDLE) ? 1'b0 : killed;
        end
    end

endmodule

//--- icache/icache_replace_unit.sv
// Valid bits and victim selection
`timescale 1ns/1ps

module icache_replace_unit import icache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  set_t              set_i,
    input  logic              rd_en_i,
    input  logic              wr_en_i,     // Accepted refill beat
    input  logic              fill_last_i,
    input  logic              flush_en_i,
    output logic [N_WAY-1:0]  tag_req_o,
    output logic [N_WAY-1:0]  data_req_o,
    output logic              tag_we_o,
    output logic [N_WAY-1:0]  valid_o,
    output way_t              victim_o
);

    logic [N_WAY-1:0]  valid_q [N_SET];
    way_t              rr_q [N_SET];     // Round-robin pointer per set
    logic              fill_done;

    assign valid_o   = valid_q[set_i];
    assign fill_done = wr_en_i && fill_last_i;
    assign tag_we_o  = fill_done;        // Tag goes in with the last beat

    // --------------------
    // Victim choice
    always_comb begin
        victim_o = rr_q[set_i];
        for (int w = N_WAY-1; w >= 0; w--) begin
            if (!valid_o[w]) victim_o = way_t'(w);  // Lowest free way wins
        end
    end

    // Reads touch every way, writes only the victim
    always_comb begin
        for (int w = 0; w < N_WAY; w++) begin
            tag_req_o[w]  = rd_en_i || (fill_done && (victim_o == way_t'(w)));
            data_req_o[w] = rd_en_i || (wr_en_i && (victim_o == way_t'(w)));
        end
    end

    // --------------------
    // Valid and pointer update
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < N_SET; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (flush_en_i) begin
            for (int s = 0; s < N_SET; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_done) begin
            valid_q[set_i][victim_o] <= 1'b1;
            rr_q[set_i]              <= rr_q[set_i] + way_t'(1);
        end
    end

endmodule

//--- icache/icache_top.sv
// Instruction cache top level
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    // Core side
    input  logic                              ireq_valid_i,
    input  logic                              ireq_kill_i,
    input  vpn_t                              ireq_vpn_i,
    input  idx_t                              ireq_idx_i,
    output logic                              iresp_ready_o,
    output logic                              iresp_valid_o,
    output line_t                             iresp_data_o,
    output logic [VPN_WIDTH+IDX_WIDTH-1:0]    iresp_vaddr_o,
    output logic                              iresp_xcpt_o,
    // MMU side
    output logic                              treq_valid_o,
    output vpn_t                              treq_vpn_o,
    input  logic                              tresp_valid_i,
    input  logic                              tresp_miss_i,
    input  logic                              tresp_ptw_valid_i,
    input  logic                              tresp_xcpt_i,
    input  ppn_t                              tresp_ppn_i,
    // Refill side
    output logic                              ifill_req_valid_o,
    output logic [PADDR_LINE_WIDTH-1:0]       ifill_req_paddr_o,
    output way_t                              ifill_req_way_o,
    input  logic                              ifill_resp_valid_i,
    input  logic                              ifill_resp_ack_i,
    input  logic [$clog2(N_BEAT)-1:0]         ifill_resp_beat_i,
    input  beat_t                             ifill_resp_data_i,
    // PMU
    output logic                              imiss_time_pmu_o,
    output logic                              imiss_kill_pmu_o
);

    vpn_t               vpn_q;
    idx_t               idx_q;
    ppn_t               tresp_ppn_q;
    logic               tresp_valid_q;
    logic               tresp_miss_q;
    logic               tresp_xcpt_q;
    logic               tresp_ptw_q;
    set_t               set_addr;
    logic               rd_en;
    logic               wr_en;
    logic               cmp_en;
    logic               flush_en;
    logic               resp_valid;
    logic               fill_beat_valid;
    logic               fill_last;
    logic [N_WAY-1:0]   tag_req;
    logic [N_WAY-1:0]   data_req;
    logic               tag_we;
    logic [N_WAY-1:0]   way_valid;
    logic [N_WAY-1:0]   hit_vec;
    ppn_t [N_WAY-1:0]   way_tags;
    line_t [N_WAY-1:0]  way_lines;

    // --------------------
    // Request and translation registers
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            vpn_q <= ireq_vpn_i;
            idx_q <= ireq_idx_i;
        end
        if (tresp_valid_i) tresp_ppn_q <= tresp_ppn_i;
    end

    // MMU answer stays valid until the next translation request
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tresp_valid_q <= 1'b0;
            tresp_miss_q  <= 1'b0;
            tresp_xcpt_q  <= 1'b0;
            tresp_ptw_q   <= 1'b0;
        end else begin
            tresp_ptw_q <= tresp_ptw_valid_i;
            if (treq_valid_o) begin
                tresp_valid_q <= 1'b0;
            end else if (tresp_valid_i) begin
                tresp_valid_q <= 1'b1;
                tresp_miss_q  <= tresp_miss_i;
                tresp_xcpt_q  <= tresp_xcpt_i;
            end
        end
    end

    assign treq_vpn_o = rd_en ? ireq_vpn_i : vpn_q;
    assign set_addr   = rd_en ? ireq_idx_i[OFFSET_WIDTH +: SET_WIDTH]
                              : idx_q[OFFSET_WIDTH +: SET_WIDTH];

    assign fill_beat_valid = ifill_resp_valid_i && ifill_resp_ack_i;
    assign fill_last       = fill_beat_valid
                             && (ifill_resp_beat_i == ($clog2(N_BEAT))'(N_BEAT - 1));

    // Line address and response
    assign ifill_req_paddr_o = {tresp_ppn_q, idx_q[IDX_WIDTH-1:OFFSET_WIDTH]};
    assign iresp_vaddr_o     = {vpn_q, idx_q};
    assign iresp_valid_o     = resp_valid;
    assign iresp_xcpt_o      = resp_valid && tresp_xcpt_q;

    icache_ctrl u_ctrl (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .flush_i           ( flush_i           ),
        .ireq_valid_i      ( ireq_valid_i      ),
        .ireq_kill_i       ( ireq_kill_i       ),
        .tresp_valid_i     ( tresp_valid_q     ),
        .tresp_miss_i      ( tresp_miss_q      ),
        .tresp_ptw_valid_i ( tresp_ptw_q       ),
        .tresp_xcpt_i      ( tresp_xcpt_q      ),
        .hit_i             ( |hit_vec          ),
        .fill_beat_valid_i ( fill_beat_valid   ),
        .fill_last_i       ( fill_last         ),
        .ready_o           ( iresp_ready_o     ),
        .treq_valid_o      ( treq_valid_o      ),
        .cmp_en_o          ( cmp_en            ),
        .rd_en_o           ( rd_en             ),
        .wr_en_o           ( wr_en             ),
        .flush_en_o        ( flush_en          ),
        .fill_req_o        ( ifill_req_valid_o ),
        .resp_valid_o      ( resp_valid        ),
        .miss_time_o       ( imiss_time_pmu_o  ),
        .miss_kill_o       ( imiss_kill_pmu_o  )
    );

    icache_replace_unit u_replace (
        .clk_i       ( clk_i           ),
        .rst_n_i     ( rst_n_i         ),
        .set_i       ( set_addr        ),
        .rd_en_i     ( rd_en           ),
        .wr_en_i     ( wr_en           ),
        .fill_last_i ( fill_last       ),
        .flush_en_i  ( flush_en        ),
        .tag_req_o   ( tag_req         ),
        .data_req_o  ( data_req        ),
        .tag_we_o    ( tag_we          ),
        .valid_o     ( way_valid       ),
        .victim_o    ( ifill_req_way_o )
    );

    // --------------------
    // Tag and line storage
    for (genvar w = 0; w < N_WAY; w++) begin : g_way
        icache_way_array #(.entry_t(ppn_t)) u_tag (
            .clk_i      ( clk_i       ),
            .req_i      ( tag_req[w]  ),
            .we_i       ( tag_we      ),
            .set_i      ( set_addr    ),
            .wdata_i    ( tresp_ppn_q ),
            .beat_sel_i ( '0          ),
            .rdata_o    ( way_tags[w] )
        );

        icache_way_array #(.entry_t(line_t)) u_data (
            .clk_i      ( clk_i                        ),
            .req_i      ( data_req[w]                  ),
            .we_i       ( wr_en                        ),
            .set_i      ( set_addr                     ),
            .wdata_i    ( {N_BEAT{ifill_resp_data_i}}  ), // Beat in every slot
            .beat_sel_i ( ifill_resp_beat_i            ),
            .rdata_o    ( way_lines[w]                 )
        );
    end

    icache_checker u_checker (
        .tags_i   ( way_tags     ),
        .lines_i  ( way_lines    ),
        .valid_i  ( way_valid    ),
        .ppn_i    ( tresp_ppn_q  ),
        .cmp_en_i ( cmp_en       ),
        .hit_o    ( hit_vec      ),
        .line_o   ( iresp_data_o )
    );

endmodule

//--- icache/icache_way_array.sv
// Single cache way storage
`timescale 1ns/1ps

module icache_way_array import icache_pkg::*; #(
    parameter type entry_t = line_t
) (
    input  logic                       clk_i,
    input  logic                       req_i,
    input  logic                       we_i,
    input  set_t                       set_i,
    input  entry_t                     wdata_i,
    input  logic [$clog2(N_BEAT)-1:0]  beat_sel_i,
    output entry_t                     rdata_o
);

    entry_t                      mem_q [N_SET];
    logic [$bits(entry_t)-1:0]   wmask;
    logic [$bits(entry_t)-1:0]   merged;

    // Lines take one refill beat per write
    if ($bits(entry_t) == LINE_WIDTH) begin : g_split
        always_comb begin
            wmask = '0;
            wmask[int'(beat_sel_i)*BEAT_WIDTH +: BEAT_WIDTH] = '1;
        end
    end else begin : g_whole
        assign wmask = '1;  // Tags are written in one go
    end

    assign merged = (mem_q[set_i] & ~wmask) | (wdata_i & wmask);

    // Write-first, so the read port shows the fresh entry
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[set_i] <= merged;
                rdata_o      <= merged;
            end else begin
                rdata_o      <= mem_q[set_i];
            end
        end
    end

endmodule

//--- test/icache_stimulus.txt
# op vpn idx ppn xcpt mmu_miss exp_miss exp_xcpt
# op is fetch, kill or flush; all numbers in hex
# cold miss, then a hit
fetch 00010 120 0a001 0 0 1 0
fetch 00010 120 0a001 0 0 0 0
# three tags in set 5, round-robin eviction
fetch 00020 050 0b001 0 0 1 0
fetch 00021 050 0b002 0 0 1 0
fetch 00022 050 0b003 0 0 1 0
fetch 00021 050 0b002 0 0 0 0
fetch 00020 050 0b001 0 0 1 0
fetch 00022 050 0b003 0 0 0 0
fetch 00021 050 0b002 0 0 1 0
fetch 00020 050 0b001 0 0 0 0
# translation exception and page walks
fetch 00030 300 0c001 1 0 0 1
fetch 00031 310 0c002 0 1 1 0
fetch 00031 310 0c002 0 0 0 0
fetch 00010 120 0a001 0 1 0 0
# kill during refill, line still lands
kill 00040 0c0 0d001 0 0 1 0
fetch 00040 0c0 0d001 0 0 0 0
# flush, then every cached line misses
flush 00000 000 00000 0 0 0 0
fetch 00010 120 0a001 0 0 1 0
fetch 00021 050 0b002 0 0 1 0
fetch 00020 050 0b001 0 0 1 0
fetch 00031 310 0c002 0 0 1 0
fetch 00040 0c0 0d001 0 0 1 0
fetch 00040 0c0 0d001 0 0 0 0
fetch 00020 050 0b001 0 0 0 0

//--- test/tb_icache.sv
// Instruction cache testbench
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

    localparam int MAX_OPS = 64;

    logic                             clk_i;
    logic                             rst_n_i;
    logic                             flush_i;
    logic                             ireq_valid_i;
    logic                             ireq_kill_i;
    vpn_t                             ireq_vpn_i;
    idx_t                             ireq_idx_i;
    logic                             iresp_ready_o;
    logic                             iresp_valid_o;
    line_t                            iresp_data_o;
    logic [VPN_WIDTH+IDX_WIDTH-1:0]   iresp_vaddr_o;
    logic                             iresp_xcpt_o;
    logic                             treq_valid_o;
    vpn_t                             treq_vpn_o;
    logic                             tresp_valid_i;
    logic                             tresp_miss_i;
    logic                             tresp_ptw_valid_i;
    logic                             tresp_xcpt_i;
    ppn_t                             tresp_ppn_i;
    logic                             ifill_req_valid_o;
    logic [PADDR_LINE_WIDTH-1:0]      ifill_req_paddr_o;
    way_t                             ifill_req_way_o;
    logic                             ifill_resp_valid_i;
    logic                             ifill_resp_ack_i;
    logic [$clog2(N_BEAT)-1:0]        ifill_resp_beat_i;
    beat_t                            ifill_resp_data_i;
    logic                             imiss_time_pmu_o;
    logic                             imiss_kill_pmu_o;

    // Operations from the stimulus file
    logic [63:0]  op_a       [MAX_OPS];
    vpn_t         vpn_a      [MAX_OPS];
    idx_t         idx_a      [MAX_OPS];
    ppn_t         ppn_a      [MAX_OPS];
    logic         xcpt_a     [MAX_OPS];
    logic         mmu_a      [MAX_OPS];
    logic         exp_miss_a [MAX_OPS];
    logic         exp_xcpt_a [MAX_OPS];
    int           n_ops;

    // Monitor state
    int                           cyc;
    int                           limit;
    int                           resp_cnt;
    int                           resp_cyc;
    line_t                        resp_data;
    logic                         resp_xcpt;
    logic [31:0]                  resp_vaddr;
    int                           fill_cnt;
    logic [PADDR_LINE_WIDTH-1:0]  fill_paddr;
    way_t                         fill_way;
    int                           last_beat_cyc;
    int                           kill_cnt;
    int                           treq_cnt;
    vpn_t                         treq_vpn;
    logic                         miss_time_seen;
    logic                         treq_seen;
    logic                         fill_start;

    // Responder state
    ppn_t   cur_ppn;
    logic   cur_xcpt;
    logic   walk_left;
    int     ptw_cnt;
    logic   fill_active;
    int     fill_beat;
    int     fill_gap;

    // Expected replacement state per set
    logic [N_WAY-1:0]  exp_valid [N_SET];
    way_t              exp_rr    [N_SET];

    icache_top dut_i (.*);

    always #5 clk_i = ~clk_i;

    // --------------------
    // Reference model
    function automatic logic [31:0] word_of(logic [PADDR_LINE_WIDTH-1:0] p, int k);
        logic [1:0] kk;
        kk = k[1:0];
        return {2'b00, p, kk};
    endfunction

    function automatic line_t refill_line(logic [PADDR_LINE_WIDTH-1:0] p);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = word_of(p, k);
        end
        return l;
    endfunction

    // Free way first, round-robin bit once the set is full
    function automatic way_t expected_victim(set_t s);
        for (int w = 0; w < N_WAY; w++) begin
            if (!exp_valid[s][w]) return way_t'(w);
        end
        return exp_rr[s];
    endfunction

    task automatic check_val(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // --------------------
    // Output monitor and timeout
    always @(posedge clk_i) begin
        if (iresp_valid_o) begin
            resp_cnt++;
            resp_cyc   = cyc;
            resp_data  = iresp_data_o;
            resp_xcpt  = iresp_xcpt_o;
            resp_vaddr = iresp_vaddr_o;
        end
        if (ifill_req_valid_o) begin
            fill_cnt++;
            fill_paddr = ifill_req_paddr_o;
            fill_way   = ifill_req_way_o;
            fill_start = 1'b1;
        end
        if (ifill_resp_valid_i && ifill_resp_ack_i && ifill_resp_beat_i == 1'b1) begin
            last_beat_cyc = cyc;  // Final refill beat taken
        end
        if (imiss_kill_pmu_o) kill_cnt++;
        if (imiss_time_pmu_o) miss_time_seen = 1'b1;
        if (treq_valid_o) begin
            treq_cnt++;
            treq_vpn = treq_vpn_o;
        end
        treq_seen = treq_valid_o;
        cyc++;
        if (limit != 0 && cyc > limit) begin
            $display("timeout: the cache stopped answering after %0d cycles", cyc);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // MMU answers one cycle after each translation request
    always @(negedge clk_i) begin
        tresp_valid_i     = 1'b0;
        tresp_ptw_valid_i = 1'b0;
        if (ptw_cnt > 0) begin
            ptw_cnt--;
            if (ptw_cnt == 0) tresp_ptw_valid_i = 1'b1;  // Page walk done
        end
        if (treq_seen) begin
            tresp_valid_i = 1'b1;
            tresp_ppn_i   = cur_ppn;
            tresp_xcpt_i  = cur_xcpt;
            tresp_miss_i  = walk_left;
            if (walk_left) begin
                walk_left = 1'b0;
                ptw_cnt   = 1 + int'($urandom % 4);
            end
        end
    end

    // Refill memory with random gaps between beats
    always @(negedge clk_i) begin
        ifill_resp_valid_i = 1'b0;
        ifill_resp_ack_i   = 1'b0;
        if (fill_start) begin
            fill_start  = 1'b0;
            fill_active = 1'b1;
            fill_beat   = 0;
            fill_gap    = int'($urandom % 3);
        end
        if (fill_active) begin
            if (fill_gap > 0) begin
                fill_gap--;
            end else begin
                ifill_resp_valid_i = 1'b1;
                ifill_resp_ack_i   = 1'b1;
                ifill_resp_beat_i  = fill_beat[0];
                ifill_resp_data_i  = {word_of(fill_paddr, 2*fill_beat + 1),
                                      word_of(fill_paddr, 2*fill_beat)};
                fill_beat++;
                fill_gap = int'($urandom % 3);
                if (fill_beat == N_BEAT) fill_active = 1'b0;
            end
        end
    end

    // --------------------
    // Operation tasks
    task automatic wait_ready();
        while (!iresp_ready_o) @(negedge clk_i);
    endtask

    task automatic fetch_and_check(int i, bit do_kill);
        int     r0;
        int     f0;
        int     k0;
        int     t0;
        int     req_cyc;
        string  name;
        set_t   set_idx;
        way_t   exp_way;
        logic [PADDR_LINE_WIDTH-1:0] exp_paddr;
        name      = $sformatf("op%0d_%0s", i, do_kill ? "kill" : "fetch");
        exp_paddr = {ppn_a[i], idx_a[i][IDX_WIDTH-1:OFFSET_WIDTH]};
        set_idx   = idx_a[i][OFFSET_WIDTH +: SET_WIDTH];
        exp_way   = expected_victim(set_idx);
        wait_ready();
        r0             = resp_cnt;
        f0             = fill_cnt;
        k0             = kill_cnt;
        t0             = treq_cnt;
        miss_time_seen = 1'b0;
        cur_ppn        = ppn_a[i];
        cur_xcpt       = xcpt_a[i];
        walk_left      = mmu_a[i];
        ireq_valid_i   = 1'b1;
        ireq_vpn_i     = vpn_a[i];
        ireq_idx_i     = idx_a[i];
        req_cyc        = cyc;
        @(negedge clk_i);
        ireq_valid_i = 1'b0;
        if (do_kill) begin
            while (fill_cnt == f0) @(negedge clk_i);
            ireq_kill_i = 1'b1;
            @(negedge clk_i);
            ireq_kill_i = 1'b0;
            wait_ready();
            check_val({name, "_resp"}, 0, resp_cnt - r0);
            check_val({name, "_kill_pulse"}, 1, kill_cnt - k0);
        end else begin
            while (resp_cnt == r0) @(negedge clk_i);
            check_val({name, "_xcpt"}, exp_xcpt_a[i], resp_xcpt);
            check_val({name, "_vaddr"}, {vpn_a[i], idx_a[i]}, resp_vaddr);
            if (!exp_xcpt_a[i]) check_val({name, "_data"}, refill_line(exp_paddr), resp_data);
            if (!exp_miss_a[i] && !mmu_a[i]) check_val({name, "_latency"}, 2, resp_cyc - req_cyc);
            if (exp_miss_a[i]) check_val({name, "_fill_latency"}, 1, resp_cyc - last_beat_cyc);
            check_val({name, "_kill_pulse"}, 0, kill_cnt - k0);
        end
        check_val({name, "_fill_req"}, exp_miss_a[i], fill_cnt - f0);
        check_val({name, "_miss_time"}, exp_miss_a[i], miss_time_seen);
        check_val({name, "_treq"}, 1 + mmu_a[i], treq_cnt - t0);
        check_val({name, "_treq_vpn"}, vpn_a[i], treq_vpn);
        if (exp_miss_a[i]) begin
            check_val({name, "_paddr"}, exp_paddr, fill_paddr);
            check_val({name, "_way"}, exp_way, fill_way);
            exp_valid[set_idx][exp_way] = 1'b1;
            exp_rr[set_idx]             = ~exp_rr[set_idx];  // Flips after every fill
        end
    endtask

    task automatic flush_cache(int i);
        wait_ready();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        @(posedge clk_i);
        check_val($sformatf("op%0d_flush_ready", i), 0, iresp_ready_o);
        @(negedge clk_i);
        for (int s = 0; s < N_SET; s++) begin
            exp_valid[s] = '0;
        end
    endtask

    task automatic load_stimulus();
        int                 fd;
        int                 n;
        logic [8*128-1:0]   buf_line;
        logic [63:0]        op;
        logic [31:0]        f [7];
        fd = $fopen("test/icache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/icache_stimulus.txt");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus");
        end
        n_ops = 0;
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            buf_line = '0;
            void'($fgets(buf_line, fd));
            n = $sscanf(buf_line, "%s %h %h %h %h %h %h %h",
                        op, f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n == 8) begin   // Comment and blank lines fall through
                op_a[n_ops]       = op;
                vpn_a[n_ops]      = f[0][VPN_WIDTH-1:0];
                idx_a[n_ops]      = f[1][IDX_WIDTH-1:0];
                ppn_a[n_ops]      = f[2][PPN_WIDTH-1:0];
                xcpt_a[n_ops]     = f[3][0];
                mmu_a[n_ops]      = f[4][0];
                exp_miss_a[n_ops] = f[5][0];
                exp_xcpt_a[n_ops] = f[6][0];
                n_ops++;
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // Main sequence
    initial begin
        void'($urandom(32'h5c5c_9377));
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        ireq_valid_i = 1'b0;
        ireq_kill_i = 1'b0;
        ireq_vpn_i = '0;
        ireq_idx_i = '0;
        tresp_valid_i = 1'b0;
        tresp_miss_i = 1'b0;
        tresp_ptw_valid_i = 1'b0;
        tresp_xcpt_i = 1'b0;
        tresp_ppn_i = '0;
        ifill_resp_valid_i = 1'b0;
        ifill_resp_ack_i = 1'b0;
        ifill_resp_beat_i = '0;
        ifill_resp_data_i = '0;
        {cyc, limit, resp_cnt, resp_cyc, fill_cnt, kill_cnt, treq_cnt, last_beat_cyc} = '0;
        {treq_seen, fill_start, fill_active, walk_left, miss_time_seen} = '0;
        {ptw_cnt, fill_beat, fill_gap} = '0;
        cur_ppn = '0;
        cur_xcpt = 1'b0;
        treq_vpn = '0;
        fill_way = '0;
        for (int s = 0; s < N_SET; s++) begin
            exp_valid[s] = '0;
            exp_rr[s]    = '0;
        end
        load_stimulus();
        limit = n_ops * 64 + 8;   // Reset cycles on top
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_val("reset_ready", 1, iresp_ready_o);
        check_val("reset_outputs", 0, {iresp_valid_o, treq_valid_o, ifill_req_valid_o,
                                       imiss_time_pmu_o, imiss_kill_pmu_o});
        for (int i = 0; i < n_ops; i++) begin
            if (op_a[i] == "flush") flush_cache(i);
            else if (op_a[i] == "kill") fetch_and_check(i, 1'b1);
            else fetch_and_check(i, 1'b0);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
